// File: logic/slot_settings.svh
`ifndef SLOT_SETTINGS_SVH
`define SLOT_SETTINGS_SVH

// DMA word and byte strobe
`define SLOT_DATA_W 128
`define SLOT_STRB_W 16

// Packet memory layout, 16 slots of 8 words
`define SLOT_COUNT 16
`define SLOT_WORDS 8
`define SLOT_ADDR_W 7

// Port map and status buses
`define SLOT_MAP_SIZE 4
`define SLOT_PORT_W 4
`define SLOT_LEN_W 16
`define SLOT_STAT_W 32
`define SLOT_STAT_ADDR_W 3
`define SLOT_CORE_ADDR_W 2

`endif

// File: logic/slot_pkg.sv
`include "slot_settings.svh"

package slot_pkg;

  typedef enum logic [1:0] {
    OP_FORWARD = 2'd0,
    OP_DROP    = 2'd1,
    OP_PASS    = 2'd2
  } desc_op_e;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_READ   = 2'd1,
    ST_LOOKUP = 2'd2,
    ST_EMIT   = 2'd3
  } eng_state_e;

  typedef struct packed {
    logic [`SLOT_ADDR_W-1:0] addr;
    logic [`SLOT_DATA_W-1:0] data;
    logic [`SLOT_STRB_W-1:0] strb;
    logic                    last;
  } dma_wr_t;

  typedef struct packed {
    logic [`SLOT_ADDR_W-1:0] addr;
    logic                    last;
  } dma_rd_t;

  // 64-bit descriptor, opcode in the top bits
  typedef struct packed {
    desc_op_e                opcode;
    logic [3:0]              slot;
    logic [`SLOT_PORT_W-1:0] port;
    logic [`SLOT_LEN_W-1:0]  length;
    logic [15:0]             tag;
    logic [21:0]             spare;
  } desc_t;

  typedef struct packed {
    logic [`SLOT_STAT_ADDR_W-1:0] addr;
    logic [`SLOT_STAT_W-1:0]      data;
  } stat_wr_t;

endpackage

// File: logic/pipe_slice.sv
`timescale 1ns/1ps

module pipe_slice #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear,
  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,
  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [WIDTH-1:0] skid_data;
  logic             main_free;

  // Output register empty or draining this cycle
  assign main_free = !m_valid || m_ready;

  // s_ready low means the skid entry holds a word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      s_ready <= 1'b1;
    end else if (clear) begin
      m_valid <= 1'b0;
      s_ready <= 1'b1;
    end else if (main_free) begin
      if (!s_ready) begin
        m_valid <= 1'b1;
        s_ready <= 1'b1;
      end else begin
        m_valid <= s_valid;
      end
    end else if (s_valid && s_ready) begin
      s_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      m_data <= s_ready ? s_data : skid_data;
    end
    if (!main_free && s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

endmodule

// File: logic/pkt_mem.sv
`timescale 1ns/1ps
`include "slot_settings.svh"

module pkt_mem (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    wr_valid,
  input  slot_pkg::dma_wr_t       wr,
  output logic                    wr_ready,

  input  logic                    rd_valid,
  input  slot_pkg::dma_rd_t       rd,
  output logic                    rd_ready,

  output logic                    resp_valid,
  output logic [`SLOT_DATA_W-1:0] resp_data,
  input  logic                    resp_ready,

  input  logic                    eng_rd_en,
  input  logic [`SLOT_ADDR_W-1:0] eng_rd_addr,
  output logic [`SLOT_DATA_W-1:0] eng_rd_data
);

  localparam int DEPTH = `SLOT_COUNT * `SLOT_WORDS;

  logic [`SLOT_DATA_W-1:0] mem [DEPTH];
  logic                    rd_take;

  assign wr_ready = 1'b1;
  // Stall new reads while the response is stuck
  assign rd_ready = !resp_valid || resp_ready;
  assign rd_take  = rd_valid && rd_ready;

  ////////////////////
  // Byte strobed write
  always_ff @(posedge clk) begin
    if (wr_valid && wr_ready) begin
      for (int b = 0; b < `SLOT_STRB_W; b++) begin
        if (wr.strb[b]) begin
          mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // DMA read response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_take) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_take) begin
      resp_data <= mem[rd.addr];
    end
    // Engine port, word held until the next read
    if (eng_rd_en) begin
      eng_rd_data <= mem[eng_rd_addr];
    end
  end

endmodule

// File: logic/desc_engine.sv
`timescale 1ns/1ps
`include "slot_settings.svh"

module desc_engine (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        core_reset,

  input  logic                                        in_valid,
  input  slot_pkg::desc_t                             in_desc,
  output logic                                        in_ready,

  output logic                                        out_valid,
  output slot_pkg::desc_t                             out_desc,
  input  logic                                        out_ready,

  output logic                                        mem_rd_en,
  output logic [`SLOT_ADDR_W-1:0]                     mem_rd_addr,
  input  logic [`SLOT_DATA_W-1:0]                     mem_rd_data,

  input  logic [`SLOT_MAP_SIZE-1:0][`SLOT_PORT_W-1:0] port_map,
  input  logic [`SLOT_LEN_W-1:0]                      min_len,

  output logic                                        accepted,
  output logic                                        done,
  output logic                                        dropped,
  output logic [`SLOT_LEN_W-1:0]                      done_len
);

  localparam int SEL_W  = $clog2(`SLOT_MAP_SIZE);
  localparam int WSEL_W = $clog2(`SLOT_WORDS);

  slot_pkg::eng_state_e state;
  slot_pkg::desc_t      cur_desc;
  logic                 rd_pend;
  logic [SEL_W-1:0]     map_sel;

  assign in_ready    = (state == slot_pkg::ST_IDLE);
  assign accepted    = in_valid && in_ready;
  // Word 0 of the slot carries the header byte
  assign mem_rd_en   = (state == slot_pkg::ST_READ) && !rd_pend;
  assign mem_rd_addr = {cur_desc.slot, {WSEL_W{1'b0}}};

  assign out_valid = (state == slot_pkg::ST_EMIT);
  assign done      = out_valid && out_ready;
  assign dropped   = done && (out_desc.opcode == slot_pkg::OP_DROP);
  // Only forwarded packets add to the byte count
  assign done_len  = (out_desc.opcode == slot_pkg::OP_FORWARD) ? out_desc.length : '0;

  ////////////////////
  // Control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= slot_pkg::ST_IDLE;
      rd_pend <= 1'b0;
    end else if (core_reset) begin
      state   <= slot_pkg::ST_IDLE;
      rd_pend <= 1'b0;
    end else begin
      case (state)
        slot_pkg::ST_IDLE: begin
          if (accepted) begin
            state <= slot_pkg::ST_READ;
          end
        end
        slot_pkg::ST_READ: begin
          // One cycle to issue, one to catch the word
          if (rd_pend) begin
            rd_pend <= 1'b0;
            state   <= slot_pkg::ST_LOOKUP;
          end else begin
            rd_pend <= 1'b1;
          end
        end
        slot_pkg::ST_LOOKUP: begin
          state <= slot_pkg::ST_EMIT;
        end
        slot_pkg::ST_EMIT: begin
          if (out_ready) begin
            state <= slot_pkg::ST_IDLE;
          end
        end
        default: state <= slot_pkg::ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // Descriptor datapath
  always_ff @(posedge clk) begin
    if (accepted) begin
      cur_desc <= in_desc;
    end
    if (state == slot_pkg::ST_READ && rd_pend) begin
      map_sel <= mem_rd_data[SEL_W-1:0];
    end
    if (state == slot_pkg::ST_LOOKUP) begin
      out_desc <= cur_desc;
      if (cur_desc.opcode == slot_pkg::OP_FORWARD) begin
        if (cur_desc.length >= min_len) begin
          out_desc.port <= port_map[map_sel];
        end else begin
          out_desc.opcode <= slot_pkg::OP_DROP;
          out_desc.port   <= '0;
        end
      end
    end
  end

endmodule

// File: logic/slot_status.sv
`timescale 1ns/1ps
`include "slot_settings.svh"

module slot_status (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        core_reset,
  input  slot_pkg::stat_wr_t                          stat_wr,
  output logic [`SLOT_MAP_SIZE-1:0][`SLOT_PORT_W-1:0] port_map,
  output logic [`SLOT_LEN_W-1:0]                      min_len,
  input  logic                                        accepted,
  input  logic                                        done,
  input  logic                                        dropped,
  input  logic [`SLOT_LEN_W-1:0]                      done_len,
  output logic [`SLOT_STAT_W-1:0]                     core_status_data,
  output logic [`SLOT_CORE_ADDR_W-1:0]                core_status_addr
);

  localparam int STAT_W = `SLOT_STAT_W;
  localparam int SEL_W  = $clog2(`SLOT_MAP_SIZE);

  logic [STAT_W-1:0] counters [4];

  // Config registers, kept through core_reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `SLOT_MAP_SIZE; i++) begin
        port_map[i] <= `SLOT_PORT_W'(i);
      end
      min_len <= '0;
    end else if (stat_wr.addr < `SLOT_STAT_ADDR_W'(`SLOT_MAP_SIZE)) begin
      port_map[stat_wr.addr[SEL_W-1:0]] <= stat_wr.data[`SLOT_PORT_W-1:0];
    end else if (stat_wr.addr == `SLOT_STAT_ADDR_W'(4)) begin
      min_len <= stat_wr.data[`SLOT_LEN_W-1:0];
    end
  end

  // Packets, drops, forwarded bytes, in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        counters[i] <= '0;
      end
    end else if (core_reset) begin
      for (int i = 0; i < 4; i++) begin
        counters[i] <= '0;
      end
    end else begin
      counters[0] <= counters[0] + STAT_W'(done);
      counters[1] <= counters[1] + STAT_W'(dropped);
      counters[2] <= counters[2] + (done ? STAT_W'(done_len) : '0);
      counters[3] <= counters[3] + STAT_W'(accepted) - STAT_W'(done);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_status_addr <= '0;
    end else begin
      core_status_addr <= core_status_addr + `SLOT_CORE_ADDR_W'(1);
    end
  end

  assign core_status_data = counters[core_status_addr];

endmodule

// File: logic/core_slot_wrap.sv
`timescale 1ns/1ps
`include "slot_settings.svh"

module core_slot_wrap (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         core_reset,

  input  logic                         dma_wr_valid,
  input  slot_pkg::dma_wr_t            dma_wr,
  output logic                         dma_wr_ready,

  input  logic                         dma_rd_valid,
  input  slot_pkg::dma_rd_t            dma_rd,
  output logic                         dma_rd_ready,

  output logic                         rd_resp_valid,
  output logic [`SLOT_DATA_W-1:0]      rd_resp_data,
  input  logic                         rd_resp_ready,

  input  logic                         in_desc_valid,
  input  slot_pkg::desc_t              in_desc,
  output logic                         in_desc_ready,

  output logic                         out_desc_valid,
  output slot_pkg::desc_t              out_desc,
  input  logic                         out_desc_ready,

  input  slot_pkg::stat_wr_t           stat_wr,
  output logic [`SLOT_STAT_W-1:0]      core_status_data,
  output logic [`SLOT_CORE_ADDR_W-1:0] core_status_addr
);

  logic                                        rst_n_r;
  logic                                        core_reset_r;
  slot_pkg::stat_wr_t                          stat_wr_r;
  slot_pkg::dma_wr_t                           dma_wr_r;
  logic                                        dma_wr_valid_r;
  logic                                        dma_wr_ready_r;
  slot_pkg::dma_rd_t                           dma_rd_r;
  logic                                        dma_rd_valid_r;
  logic                                        dma_rd_ready_r;
  logic [`SLOT_DATA_W-1:0]                     resp_data_n;
  logic                                        resp_valid_n;
  logic                                        resp_ready_n;
  slot_pkg::desc_t                             in_desc_r;
  logic                                        in_desc_valid_r;
  logic                                        in_desc_ready_r;
  slot_pkg::desc_t                             out_desc_n;
  logic                                        out_desc_valid_n;
  logic                                        out_desc_ready_n;
  logic                                        eng_rd_en;
  logic [`SLOT_ADDR_W-1:0]                     eng_rd_addr;
  logic [`SLOT_DATA_W-1:0]                     eng_rd_data;
  logic [`SLOT_MAP_SIZE-1:0][`SLOT_PORT_W-1:0] port_map;
  logic [`SLOT_LEN_W-1:0]                      min_len;
  logic                                        accepted;
  logic                                        done;
  logic                                        dropped;
  logic [`SLOT_LEN_W-1:0]                      done_len;
  logic [`SLOT_STAT_W-1:0]                     status_data_n;
  logic [`SLOT_CORE_ADDR_W-1:0]                status_addr_n;

  ////////////////////
  // Boundary registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_n_r <= 1'b0;
    end else begin
      rst_n_r <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_r) begin
    if (!rst_n_r) begin
      core_reset_r     <= 1'b0;
      stat_wr_r.addr   <= '1;
      stat_wr_r.data   <= '0;
      core_status_data <= '0;
      core_status_addr <= '0;
    end else begin
      core_reset_r     <= core_reset;
      stat_wr_r        <= stat_wr;
      core_status_data <= status_data_n;
      core_status_addr <= status_addr_n;
    end
  end

  ////////////////////
  // Channel slices
  pipe_slice #(.WIDTH($bits(slot_pkg::dma_wr_t))) i_dma_wr_slice (
    .clk(clk), .rst_n(rst_n_r), .clear(1'b0),
    .s_data(dma_wr), .s_valid(dma_wr_valid), .s_ready(dma_wr_ready),
    .m_data(dma_wr_r), .m_valid(dma_wr_valid_r), .m_ready(dma_wr_ready_r)
  );

  pipe_slice #(.WIDTH($bits(slot_pkg::dma_rd_t))) i_dma_rd_slice (
    .clk(clk), .rst_n(rst_n_r), .clear(1'b0),
    .s_data(dma_rd), .s_valid(dma_rd_valid), .s_ready(dma_rd_ready),
    .m_data(dma_rd_r), .m_valid(dma_rd_valid_r), .m_ready(dma_rd_ready_r)
  );

  pipe_slice #(.WIDTH(`SLOT_DATA_W)) i_rd_resp_slice (
    .clk(clk), .rst_n(rst_n_r), .clear(1'b0),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(rd_resp_data), .m_valid(rd_resp_valid), .m_ready(rd_resp_ready)
  );

  // Descriptor slices also flush on core reset
  pipe_slice #(.WIDTH($bits(slot_pkg::desc_t))) i_in_desc_slice (
    .clk(clk), .rst_n(rst_n_r), .clear(core_reset_r),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_ready),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_ready_r)
  );

  pipe_slice #(.WIDTH($bits(slot_pkg::desc_t))) i_out_desc_slice (
    .clk(clk), .rst_n(rst_n_r), .clear(core_reset_r),
    .s_data(out_desc_n), .s_valid(out_desc_valid_n), .s_ready(out_desc_ready_n),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  ////////////////////
  // Slot logic
  pkt_mem i_pkt_mem (
    .clk(clk), .rst_n(rst_n_r),
    .wr_valid(dma_wr_valid_r), .wr(dma_wr_r), .wr_ready(dma_wr_ready_r),
    .rd_valid(dma_rd_valid_r), .rd(dma_rd_r), .rd_ready(dma_rd_ready_r),
    .resp_valid(resp_valid_n), .resp_data(resp_data_n), .resp_ready(resp_ready_n),
    .eng_rd_en(eng_rd_en), .eng_rd_addr(eng_rd_addr), .eng_rd_data(eng_rd_data)
  );

  desc_engine i_desc_engine (
    .clk(clk), .rst_n(rst_n_r), .core_reset(core_reset_r),
    .in_valid(in_desc_valid_r), .in_desc(in_desc_r), .in_ready(in_desc_ready_r),
    .out_valid(out_desc_valid_n), .out_desc(out_desc_n), .out_ready(out_desc_ready_n),
    .mem_rd_en(eng_rd_en), .mem_rd_addr(eng_rd_addr), .mem_rd_data(eng_rd_data),
    .port_map(port_map), .min_len(min_len),
    .accepted(accepted), .done(done), .dropped(dropped), .done_len(done_len)
  );

  slot_status i_slot_status (
    .clk(clk), .rst_n(rst_n_r), .core_reset(core_reset_r),
    .stat_wr(stat_wr_r), .port_map(port_map), .min_len(min_len),
    .accepted(accepted), .done(done), .dropped(dropped), .done_len(done_len),
    .core_status_data(status_data_n), .core_status_addr(status_addr_n)
  );

endmodule

// File: bench/slot_checker.sv
`timescale 1ns/1ps
`include "slot_settings.svh"

module slot_checker (
  input logic                         clk,
  input logic                         dma_rd_valid,
  input logic                         dma_rd_ready,
  input logic                         rd_resp_valid,
  input logic                         rd_resp_ready,
  input logic [`SLOT_DATA_W-1:0]      rd_resp_data,
  input logic                         out_desc_valid,
  input logic                         out_desc_ready,
  input slot_pkg::desc_t              out_desc,
  input logic [`SLOT_STAT_W-1:0]      core_status_data,
  input logic [`SLOT_CORE_ADDR_W-1:0] core_status_addr
);

  typedef struct packed {
    logic                    timed;
    logic [`SLOT_DATA_W-1:0] data;
  } read_exp_t;

  typedef struct packed {
    logic [`SLOT_CORE_ADDR_W-1:0] idx;
    logic [`SLOT_STAT_W-1:0]      value;
  } status_exp_t;

  read_exp_t       read_q [$];
  slot_pkg::desc_t desc_q [$];
  status_exp_t     status_q [$];
  int unsigned     accept_q [$];
  int unsigned     edge_cnt = 0;
  int              errors = 0;

  task automatic expect_read(input logic [`SLOT_DATA_W-1:0] data, input logic timed);
    read_q.push_back('{timed: timed, data: data});
  endtask

  task automatic expect_desc(input slot_pkg::desc_t desc);
    desc_q.push_back(desc);
  endtask

  task automatic expect_status(input logic [`SLOT_CORE_ADDR_W-1:0] idx,
                               input logic [`SLOT_STAT_W-1:0] value);
    status_q.push_back('{idx: idx, value: value});
  endtask

  function automatic int pending();
    return read_q.size() + desc_q.size() + status_q.size();
  endfunction

  always @(posedge clk) begin : monitor
    read_exp_t       r;
    slot_pkg::desc_t d;
    status_exp_t     s;
    int unsigned     acc;
    edge_cnt++;
    // Edge count of each accepted read command, for the latency check
    if (dma_rd_valid && dma_rd_ready) begin
      accept_q.push_back(edge_cnt);
    end
    if (rd_resp_valid && rd_resp_ready) begin
      if (read_q.size() == 0 || accept_q.size() == 0) begin
        $display("Read response arrived with no read outstanding");
        errors++;
      end else begin
        r   = read_q.pop_front();
        acc = accept_q.pop_front();
        if (rd_resp_data !== r.data) begin
          $display("Mismatch rd_resp_data: got %h, expected %h", rd_resp_data, r.data);
          errors++;
        end
        if (r.timed && edge_cnt - acc != 3) begin
          $display("Read response came %0d cycles after its command, not 3", edge_cnt - acc);
          errors++;
        end
      end
    end
    if (out_desc_valid && out_desc_ready) begin
      if (desc_q.size() == 0) begin
        $display("Out descriptor %h arrived with none expected", out_desc);
        errors++;
      end else begin
        d = desc_q.pop_front();
        if (out_desc !== d) begin
          $display("Mismatch out_desc: got %h, expected %h", out_desc, d);
          errors++;
        end
      end
    end
    if (status_q.size() != 0 && core_status_addr == status_q[0].idx) begin
      s = status_q.pop_front();
      if (core_status_data !== s.value) begin
        $display("Mismatch core_status_data[%0d]: got %h, expected %h",
                 s.idx, core_status_data, s.value);
        errors++;
      end
    end
  end

endmodule

// File: bench/core_slot_wrap_tb.sv
`timescale 1ns/1ps
`include "slot_settings.svh"

module core_slot_wrap_tb;

  typedef enum logic [2:0] {
    E_WR, E_STAT, E_RD, E_RD_TIMED, E_DESC, E_RESET, E_STATUS
  } kind_e;

  // addr is a word address, a status register or a counter index
  typedef struct packed {
    kind_e                   kind;
    logic [`SLOT_ADDR_W-1:0] addr;
    logic [`SLOT_DATA_W-1:0] data;
    logic [`SLOT_STRB_W-1:0] strb;
    slot_pkg::desc_t         desc;
    slot_pkg::desc_t         exp_desc;
  } entry_t;

  localparam int TIMEOUT = 400;
  localparam slot_pkg::desc_op_e FWD  = slot_pkg::OP_FORWARD;
  localparam slot_pkg::desc_op_e DROP = slot_pkg::OP_DROP;
  localparam slot_pkg::desc_op_e PASS = slot_pkg::OP_PASS;

  logic                         clk;
  logic                         rst_n;
  logic                         core_reset;
  logic                         dma_wr_valid;
  slot_pkg::dma_wr_t            dma_wr;
  logic                         dma_wr_ready;
  logic                         dma_rd_valid;
  slot_pkg::dma_rd_t            dma_rd;
  logic                         dma_rd_ready;
  logic                         rd_resp_valid;
  logic [`SLOT_DATA_W-1:0]      rd_resp_data;
  logic                         rd_resp_ready;
  logic                         in_desc_valid;
  slot_pkg::desc_t              in_desc;
  logic                         in_desc_ready;
  logic                         out_desc_valid;
  slot_pkg::desc_t              out_desc;
  logic                         out_desc_ready;
  slot_pkg::stat_wr_t           stat_wr;
  logic [`SLOT_STAT_W-1:0]      core_status_data;
  logic [`SLOT_CORE_ADDR_W-1:0] core_status_addr;

  entry_t tbl [$];
  int     seed = 94;
  int     timeouts = 0;
  logic   hold_ready;

  core_slot_wrap i_dut (.*);

  slot_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random back-pressure on both output channels
  initial begin
    out_desc_ready = 1'b0;
    rd_resp_ready  = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_desc_ready = (($random(seed) & 3) != 0);
      rd_resp_ready  = hold_ready ? 1'b1 : (($random(seed) & 3) != 0);
    end
  end

  function automatic entry_t table_row(input kind_e kind, input logic [`SLOT_ADDR_W-1:0] addr,
                                       input logic [`SLOT_DATA_W-1:0] data,
                                       input logic [`SLOT_STRB_W-1:0] strb);
    entry_t e;
    e      = '0;
    e.kind = kind;
    e.addr = addr;
    e.data = data;
    e.strb = strb;
    return e;
  endfunction

  // Out descriptor keeps slot, length and tag
  function automatic entry_t desc_row(input slot_pkg::desc_op_e op, input logic [3:0] slot,
                                      input logic [3:0] port, input logic [15:0] len,
                                      input logic [15:0] tag, input slot_pkg::desc_op_e exp_op,
                                      input logic [3:0] exp_port);
    entry_t e;
    e = table_row(E_DESC, '0, '0, '0);
    e.desc = '{opcode: op, slot: slot, port: port, length: len, tag: tag, spare: '0};
    e.exp_desc        = e.desc;
    e.exp_desc.opcode = exp_op;
    e.exp_desc.port   = exp_port;
    return e;
  endfunction

  ////////////////////
  // Stimulus table
  task automatic build_table();
    // Slot 1 word 0 gets bytes 4 to 7 patched, slot 2 word 0 is written in halves
    tbl.push_back(table_row(E_WR, 7'd0, 128'h11111111_22222222_33333333_44444401, 16'hffff));
    tbl.push_back(table_row(E_WR, 7'd8, 128'h00112233_44556677_8899aabb_ccddeeff, 16'hffff));
    tbl.push_back(table_row(E_WR, 7'd8, 128'h5a5a5a5a_5a5a5a5a_5a5a5a5a_5a5a5a5a, 16'h00f0));
    tbl.push_back(table_row(E_WR, 7'd16, 128'hffffffff_ffffffff_12345678_9abcde02, 16'h00ff));
    tbl.push_back(table_row(E_WR, 7'd16, 128'hdeadbeef_0badf00d_00000000_00000000, 16'hff00));
    tbl.push_back(table_row(E_WR, 7'd17, 128'h01020304_05060708_090a0b0c_0d0e0f10, 16'hffff));
    tbl.push_back(table_row(E_RD, 7'd8, 128'h00112233_44556677_5a5a5a5a_ccddeeff, '0));
    tbl.push_back(table_row(E_RD, 7'd16, 128'hdeadbeef_0badf00d_12345678_9abcde02, '0));
    tbl.push_back(table_row(E_RD, 7'd0, 128'h11111111_22222222_33333333_44444401, '0));
    tbl.push_back(table_row(E_RD, 7'd17, 128'h01020304_05060708_090a0b0c_0d0e0f10, '0));
    tbl.push_back(table_row(E_RD, 7'd8, 128'h00112233_44556677_5a5a5a5a_ccddeeff, '0));
    tbl.push_back(table_row(E_RD_TIMED, 7'd16, 128'hdeadbeef_0badf00d_12345678_9abcde02, '0));
    // Identity port map, header selects 3, 1 and 2
    tbl.push_back(desc_row(FWD, 4'd1, 4'd9, 16'd100, 16'h0a01, FWD, 4'd3));
    tbl.push_back(desc_row(FWD, 4'd0, 4'd0, 16'd64, 16'h0a02, FWD, 4'd1));
    tbl.push_back(desc_row(PASS, 4'd2, 4'd7, 16'd20, 16'h0a03, PASS, 4'd7));
    tbl.push_back(desc_row(FWD, 4'd2, 4'd0, 16'd40, 16'h0a04, FWD, 4'd2));
    tbl.push_back(table_row(E_STATUS, 7'd0, 128'd4, '0));
    tbl.push_back(table_row(E_STATUS, 7'd1, 128'd0, '0));
    tbl.push_back(table_row(E_STATUS, 7'd2, 128'd204, '0));
    tbl.push_back(table_row(E_STATUS, 7'd3, 128'd0, '0));
    tbl.push_back(table_row(E_STAT, 7'd3, 128'hc, '0));
    tbl.push_back(table_row(E_STAT, 7'd1, 128'h5, '0));
    tbl.push_back(table_row(E_STAT, 7'd2, 128'he, '0));
    tbl.push_back(table_row(E_STAT, 7'd4, 128'd50, '0));
    tbl.push_back(desc_row(FWD, 4'd1, 4'd9, 16'd100, 16'h0b01, FWD, 4'hc));
    tbl.push_back(desc_row(FWD, 4'd0, 4'd4, 16'd30, 16'h0b02, DROP, 4'd0));
    tbl.push_back(desc_row(FWD, 4'd2, 4'd1, 16'd50, 16'h0b03, FWD, 4'he));
    tbl.push_back(desc_row(PASS, 4'd0, 4'd5, 16'd10, 16'h0b04, PASS, 4'd5));
    tbl.push_back(desc_row(FWD, 4'd0, 4'd0, 16'd80, 16'h0b05, FWD, 4'd5));
    tbl.push_back(table_row(E_STATUS, 7'd0, 128'd9, '0));
    tbl.push_back(table_row(E_STATUS, 7'd1, 128'd1, '0));
    tbl.push_back(table_row(E_STATUS, 7'd2, 128'd434, '0));
    tbl.push_back(table_row(E_STATUS, 7'd3, 128'd0, '0));
    tbl.push_back(table_row(E_RESET, '0, '0, '0));
    tbl.push_back(table_row(E_STATUS, 7'd0, 128'd0, '0));
    tbl.push_back(table_row(E_STATUS, 7'd1, 128'd0, '0));
    tbl.push_back(table_row(E_STATUS, 7'd2, 128'd0, '0));
    tbl.push_back(table_row(E_STATUS, 7'd3, 128'd0, '0));
    // Memory, port map and min_len survive core reset
    tbl.push_back(desc_row(FWD, 4'd1, 4'd0, 16'd60, 16'h0c01, FWD, 4'hc));
    tbl.push_back(desc_row(FWD, 4'd0, 4'd3, 16'd20, 16'h0c02, DROP, 4'd0));
    tbl.push_back(table_row(E_RD, 7'd8, 128'h00112233_44556677_5a5a5a5a_ccddeeff, '0));
    tbl.push_back(table_row(E_STATUS, 7'd0, 128'd2, '0));
    tbl.push_back(table_row(E_STATUS, 7'd1, 128'd1, '0));
    tbl.push_back(table_row(E_STATUS, 7'd2, 128'd60, '0));
  endtask

  ////////////////////
  // Handshake and wait loops
  task automatic transfer(input kind_e k, input string what);
    logic taken;
    int   n;
    taken = 1'b0;
    n     = 0;
    while (!taken && timeouts == 0) begin
      if (k == E_WR) begin
        taken = dma_wr_ready;
      end else if (k == E_DESC) begin
        taken = in_desc_ready;
      end else begin
        taken = dma_rd_ready;
      end
      @(posedge clk);
      #1;
      n++;
      if (!taken && n == TIMEOUT) begin
        $display("Timeout: the %s was never accepted", what);
        timeouts++;
      end
    end
    dma_wr_valid  = 1'b0;
    dma_rd_valid  = 1'b0;
    in_desc_valid = 1'b0;
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while (i_checker.pending() != 0 && timeouts == 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n == TIMEOUT) begin
        $display("Timeout: still waiting for %s", what);
        timeouts++;
      end
    end
  endtask

  task automatic apply_entry(input entry_t e);
    case (e.kind)
      E_WR: begin
        dma_wr       = '{addr: e.addr, data: e.data, strb: e.strb, last: 1'b1};
        dma_wr_valid = 1'b1;
        transfer(E_WR, "DMA write");
      end
      E_STAT: begin
        stat_wr = '{addr: e.addr[2:0], data: e.data[31:0]};
        @(posedge clk);
        #1;
        stat_wr.addr = 3'd7;
      end
      E_RD, E_RD_TIMED: begin
        if (e.kind == E_RD_TIMED) begin
          drain("earlier read responses");
          hold_ready = 1'b1;
          @(posedge clk);
          #1;
        end
        i_checker.expect_read(e.data, e.kind == E_RD_TIMED);
        dma_rd       = '{addr: e.addr, last: 1'b1};
        dma_rd_valid = 1'b1;
        transfer(E_RD, "DMA read command");
        if (e.kind == E_RD_TIMED) begin
          drain("the timed read response");
          hold_ready = 1'b0;
        end
      end
      E_DESC: begin
        i_checker.expect_desc(e.exp_desc);
        in_desc       = e.desc;
        in_desc_valid = 1'b1;
        transfer(E_DESC, "input descriptor");
      end
      E_RESET: begin
        drain("descriptors ahead of core reset");
        core_reset = 1'b1;
        @(posedge clk);
        #1;
        core_reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
      end
      default: begin
        // Status is checked once every descriptor is out
        drain("descriptors ahead of a status check");
        i_checker.expect_status(e.addr[1:0], e.data[31:0]);
        drain("the status value");
      end
    endcase
  endtask

  initial begin
    rst_n         = 1'b0;
    core_reset    = 1'b0;
    dma_wr_valid  = 1'b0;
    dma_wr        = '0;
    dma_rd_valid  = 1'b0;
    dma_rd        = '0;
    in_desc_valid = 1'b0;
    in_desc       = '0;
    stat_wr       = '{addr: 3'd7, data: '0};
    hold_ready    = 1'b0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Reset is registered inside the wrapper
    repeat (2) @(posedge clk);
    #1;
    foreach (tbl[i]) begin
      if (timeouts == 0) begin
        apply_entry(tbl[i]);
      end
    end
    drain("the last responses");
    $display("Checker errors: %0d, timeouts: %0d", i_checker.errors, timeouts);
    if (i_checker.errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: core_slot_wrap.f
+incdir+logic
logic/slot_pkg.sv
logic/pipe_slice.sv
logic/pkt_mem.sv
logic/desc_engine.sv
logic/slot_status.sv
logic/core_slot_wrap.sv
bench/slot_checker.sv
bench/core_slot_wrap_tb.sv

// File: Makefile
SIM      := verilator
TOP      := core_slot_wrap_tb
FILELIST := core_slot_wrap.f
FLAGS    := --binary -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
